// File: hw/mmio_pkg.sv
package mmio_pkg;

	localparam int IRQ_W = 6; // hwirq[7:2]

	typedef enum logic [2:0] {
		DM_NONE = 3'd0,
		DM_WORD = 3'd1,
		DM_HALF = 3'd2,
		DM_BYTE = 3'd3
	} dm_mode_e;

	typedef enum logic [3:0] {
		DEV_TIMER    = 4'd0,
		DEV_SWITCHES = 4'd2,
		DEV_LED      = 4'd3,
		DEV_BUTTONS  = 4'd5,
		DEV_NONE     = 4'd15
	} dev_id_e;

	localparam logic [31:0] TIMER_LB    = 32'h0000_7F00;
	localparam logic [31:0] TIMER_UB    = 32'h0000_7F0B;
	localparam logic [31:0] LED_LB      = 32'h0000_7F10;
	localparam logic [31:0] LED_UB      = 32'h0000_7F13;
	localparam logic [31:0] SWITCHES_LB = 32'h0000_7F20;
	localparam logic [31:0] SWITCHES_UB = 32'h0000_7F23;
	localparam logic [31:0] BUTTONS_LB  = 32'h0000_7F30;
	localparam logic [31:0] BUTTONS_UB  = 32'h0000_7F33;

	localparam logic [31:0] TIMER_CTRL_OFS   = 32'd0;
	localparam logic [31:0] TIMER_PRESET_OFS = 32'd4;
	localparam logic [31:0] TIMER_COUNT_OFS  = 32'd8;

	typedef enum logic [1:0] {
		TMR_ONESHOT = 2'd0,
		TMR_RELOAD  = 2'd1
	} timer_mode_e;

	typedef struct packed {
		logic [27:0] rsvd;
		logic        irq_mask;
		timer_mode_e mode;
		logic        enable;
	} timer_ctrl_t;

	typedef union packed {
		logic [31:0] word; // Bus view
		timer_ctrl_t f;    // Field view for the counter
	} timer_ctrl_u;

endpackage

// File: hw/dev_bus_if.sv
`timescale 1ns/1ps

interface dev_bus_if;

	logic [31:0] addr; // Offset inside the device window
	logic        write_enable;
	logic [31:0] write_data;
	logic [31:0] read_result;
	logic        irq;

	modport bridge (
		output addr, write_enable, write_data,
		input  read_result, irq
	);

	modport device (
		input  addr, write_enable, write_data,
		output read_result, irq
	);

endinterface

// File: hw/bridge.sv
`timescale 1ns/1ps

module bridge import mmio_pkg::*; (
	input  dm_mode_e         dm_mode,
	input  logic             stop,
	input  logic [31:0]      addr,
	input  logic             write_enable,
	input  logic [31:0]      write_data,
	output logic [31:0]      read_data,
	output logic             valid,
	output logic [IRQ_W+1:2] hwirq,
	dev_bus_if.bridge        tmr,
	dev_bus_if.bridge        led,
	dev_bus_if.bridge        sw,
	dev_bus_if.bridge        btn
);

	dev_id_e     dev;
	logic [31:0] base;
	logic [31:0] ofs;
	logic        tmr_ok;
	logic        wr_go;

	function automatic logic in_win(
		input logic [31:0] a,
		input logic [31:0] lb,
		input logic [31:0] ub
	);
		return (a >= lb) && (a <= ub);
	endfunction

	always_comb begin
		if (in_win(addr, TIMER_LB, TIMER_UB)) begin
			dev  = DEV_TIMER;
			base = TIMER_LB;
		end else if (in_win(addr, LED_LB, LED_UB)) begin
			dev  = DEV_LED;
			base = LED_LB;
		end else if (in_win(addr, SWITCHES_LB, SWITCHES_UB)) begin
			dev  = DEV_SWITCHES;
			base = SWITCHES_LB;
		end else if (in_win(addr, BUTTONS_LB, BUTTONS_UB)) begin
			dev  = DEV_BUTTONS;
			base = BUTTONS_LB;
		end else begin
			dev  = DEV_NONE;
			base = '0;
		end
	end

	assign ofs = addr - base;

	// Timer takes aligned words only and its count register is read-only
	assign tmr_ok = (dm_mode == DM_WORD) && (addr[1:0] == 2'b00) &&
		!(write_enable && (ofs == TIMER_COUNT_OFS));

	always_comb begin
		case (dev)
			DEV_TIMER:                          valid = (dm_mode == DM_NONE) || tmr_ok;
			DEV_LED, DEV_SWITCHES, DEV_BUTTONS: valid = 1'b1;
			default:                            valid = (dm_mode == DM_NONE);
		endcase
	end

	assign wr_go = valid && write_enable && !stop; // Stop holds back writes only

	assign tmr.addr         = (dev == DEV_TIMER) ? ofs : '0;
	assign tmr.write_enable = wr_go && (dev == DEV_TIMER);
	assign tmr.write_data   = write_data;

	assign led.addr         = (dev == DEV_LED) ? ofs : '0;
	assign led.write_enable = wr_go && (dev == DEV_LED);
	assign led.write_data   = write_data;

	assign sw.addr          = (dev == DEV_SWITCHES) ? ofs : '0;
	assign sw.write_enable  = wr_go && (dev == DEV_SWITCHES);
	assign sw.write_data    = write_data;

	assign btn.addr         = (dev == DEV_BUTTONS) ? ofs : '0;
	assign btn.write_enable = wr_go && (dev == DEV_BUTTONS);
	assign btn.write_data   = write_data;

	always_comb begin
		case (dev)
			DEV_TIMER:    read_data = tmr.read_result;
			DEV_LED:      read_data = led.read_result;
			DEV_SWITCHES: read_data = sw.read_result;
			DEV_BUTTONS:  read_data = btn.read_result;
			default:      read_data = '0; // Unmapped
		endcase
	end

	// Bits 3 and 6 were the serial port and display slots
	assign hwirq = {btn.irq, 1'b0, led.irq, sw.irq, 1'b0, tmr.irq};

	always_comb begin
		assert ($onehot0({tmr.write_enable, led.write_enable, sw.write_enable,
			btn.write_enable}))
			else $error("bridge: more than one device write strobe");
	end

endmodule

// File: hw/timer.sv
`timescale 1ns/1ps

module timer import mmio_pkg::*; (
	input logic       clk,
	input logic       arst_n,
	dev_bus_if.device bus
);

	timer_ctrl_u ctrl;
	logic [31:0] preset;
	logic [31:0] count;
	logic        irq_flag;
	logic        ctrl_wr;
	logic        preset_wr;

	assign ctrl_wr   = bus.write_enable && (bus.addr == TIMER_CTRL_OFS);
	assign preset_wr = bus.write_enable && (bus.addr == TIMER_PRESET_OFS);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl.word <= '0;
			preset    <= '0;
			count     <= '0;
			irq_flag  <= 1'b0;
		end else if (ctrl_wr) begin
			ctrl.word <= bus.write_data;
			irq_flag  <= 1'b0; // Any ctrl write acknowledges
		end else if (preset_wr) begin
			preset <= bus.write_data;
			count  <= bus.write_data;
		end else if (ctrl.f.enable) begin
			if (count != '0) begin
				count <= count - 32'd1;
			end else begin
				irq_flag <= 1'b1;
				if (ctrl.f.mode == TMR_RELOAD)
					count <= preset;
				else
					ctrl.f.enable <= 1'b0; // One-shot stops at zero
			end
		end
	end

	always_comb begin
		case (bus.addr)
			TIMER_CTRL_OFS:   bus.read_result = ctrl.word;
			TIMER_PRESET_OFS: bus.read_result = preset;
			TIMER_COUNT_OFS:  bus.read_result = count;
			default:          bus.read_result = '0;
		endcase
	end

	assign bus.irq = irq_flag & ctrl.f.irq_mask;

	assert property (@(posedge clk) disable iff (!arst_n)
		(ctrl.f.enable && !preset_wr) |-> (count <= preset))
		else $error("timer: count above preset while running");

endmodule

// File: hw/led_port.sv
`timescale 1ns/1ps

module led_port (
	input  logic        clk,
	input  logic        arst_n,
	dev_bus_if.device   bus,
	output logic [15:0] leds
);

	logic [15:0] led_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			led_q <= '0;
		else if (bus.write_enable)
			led_q <= bus.write_data[15:0]; // Upper half ignored
	end

	assign leds            = led_q;
	assign bus.read_result = {16'h0000, led_q};
	assign bus.irq         = 1'b0; // No interrupt source

endmodule

// File: hw/input_port.sv
`timescale 1ns/1ps

module input_port #(
	parameter int WIDTH = 16
) (
	input logic             clk,
	input logic             arst_n,
	input logic [WIDTH-1:0] pins,
	dev_bus_if.device       bus
);

	logic [WIDTH-1:0] sync1;
	logic [WIDTH-1:0] sync2;
	logic [WIDTH-1:0] sync_d; // Last synchronized value for edge detect
	logic             irq_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync1  <= '0;
			sync2  <= '0;
			sync_d <= '0;
		end else begin
			sync1  <= pins;
			sync2  <= sync1;
			sync_d <= sync2;
		end
	end

	// A change wins over a clearing write so no event is lost
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			irq_q <= 1'b0;
		else if (sync2 != sync_d)
			irq_q <= 1'b1;
		else if (bus.write_enable)
			irq_q <= 1'b0;
	end

	assign bus.read_result = 32'(sync2);
	assign bus.irq         = irq_q;

	assert property (@(posedge clk) disable iff (!arst_n)
		$fell(irq_q) |-> $past(bus.write_enable))
		else $error("input_port: irq cleared without a write");

endmodule

// File: hw/mmio_top.sv
`timescale 1ns/1ps

module mmio_top import mmio_pkg::*; #(
	parameter int SW_WIDTH  = 16,
	parameter int BTN_WIDTH = 5
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  dm_mode_e             dm_mode,
	input  logic                 stop,
	input  logic [31:0]          addr,
	input  logic                 write_enable,
	input  logic [31:0]          write_data,
	output logic [31:0]          read_data,
	output logic                 valid,
	output logic [IRQ_W+1:2]     hwirq,
	output logic [15:0]          leds,
	input  logic [SW_WIDTH-1:0]  switches,
	input  logic [BTN_WIDTH-1:0] buttons
);

	dev_bus_if tmr_bus ();
	dev_bus_if led_bus ();
	dev_bus_if sw_bus ();
	dev_bus_if btn_bus ();

	bridge u_bridge (
		.dm_mode      (dm_mode),
		.stop         (stop),
		.addr         (addr),
		.write_enable (write_enable),
		.write_data   (write_data),
		.read_data    (read_data),
		.valid        (valid),
		.hwirq        (hwirq),
		.tmr          (tmr_bus),
		.led          (led_bus),
		.sw           (sw_bus),
		.btn          (btn_bus)
	);

	timer u_timer (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (tmr_bus)
	);

	led_port u_led (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (led_bus),
		.leds   (leds)
	);

	input_port #(
		.WIDTH (SW_WIDTH)
	) u_switches (
		.clk    (clk),
		.arst_n (arst_n),
		.pins   (switches),
		.bus    (sw_bus)
	);

	input_port #(
		.WIDTH (BTN_WIDTH)
	) u_buttons (
		.clk    (clk),
		.arst_n (arst_n),
		.pins   (buttons),
		.bus    (btn_bus)
	);

endmodule

// File: bench/mmio_top_tb.sv
`timescale 1ns/1ps

module mmio_top_tb import mmio_pkg::*; ();

	localparam int MAX_RECS = 64;

	logic             clk;
	logic             arst_n;
	dm_mode_e         dm_mode;
	logic             stop;
	logic [31:0]      addr;
	logic             write_enable;
	logic [31:0]      write_data;
	logic [31:0]      read_data;
	logic             valid;
	logic [IRQ_W+1:2] hwirq;
	logic [15:0]      leds;
	logic [15:0]      switches;
	logic [4:0]       buttons;

	logic [111:0] recs [0:MAX_RECS-1]; // op, addr, data, mode, expected

	mmio_top #(
		.SW_WIDTH  (16),
		.BTN_WIDTH (5)
	) uut (
		.clk          (clk),
		.arst_n       (arst_n),
		.dm_mode      (dm_mode),
		.stop         (stop),
		.addr         (addr),
		.write_enable (write_enable),
		.write_data   (write_data),
		.read_data    (read_data),
		.valid        (valid),
		.hwirq        (hwirq),
		.leds         (leds),
		.switches     (switches),
		.buttons      (buttons)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s (got %h, expected %h)", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		dm_mode      = DM_NONE; // Bus idles between operations
		write_enable = 1'b0;
		addr         = '0;
		write_data   = '0;
	endtask

	function automatic logic model_mapped(input logic [31:0] a);
		return (a >= TIMER_LB && a <= TIMER_UB) || (a >= LED_LB && a <= LED_UB) ||
			(a >= SWITCHES_LB && a <= SWITCHES_UB) || (a >= BUTTONS_LB && a <= BUTTONS_UB);
	endfunction

	function automatic logic model_valid(input logic [31:0] a, input logic [2:0] m,
		input logic we);
		logic is_tmr;
		is_tmr = (a >= TIMER_LB) && (a <= TIMER_UB);
		if (m == DM_NONE)
			return 1'b1;
		if (!model_mapped(a))
			return 1'b0;
		if (!is_tmr)
			return 1'b1;
		// Timer wants aligned words and never takes a count write
		return (m == DM_WORD) && (a[1:0] == 2'b00) &&
			!(we && (a == TIMER_LB + TIMER_COUNT_OFS));
	endfunction

	task automatic drive_access(input logic [31:0] a, input logic [2:0] m, input logic we,
		input logic [31:0] d);
		next_cycle();
		dm_mode      = dm_mode_e'(m);
		addr         = a;
		write_enable = we;
		write_data   = d;
		@(negedge clk);
	endtask

	task automatic do_write(input logic [31:0] a, input logic [31:0] d, input logic [2:0] m,
		input logic [31:0] e);
		drive_access(a, m, 1'b1, d);
		check(32'(model_valid(a, m, 1'b1)), e, "map model disagrees with test file");
		check(32'(valid), e, $sformatf("valid on write to %h", a));
	endtask

	task automatic do_access(input logic [31:0] a, input logic [2:0] m, input logic [31:0] e);
		drive_access(a, m, 1'b0, '0);
		check(32'(model_valid(a, m, 1'b0)), e, "map model disagrees with test file");
		check(32'(valid), e, $sformatf("valid on access to %h", a));
	endtask

	task automatic do_read(input logic [31:0] a, input logic [2:0] m, input logic [31:0] e);
		drive_access(a, m, 1'b0, '0);
		check(32'(valid), 32'(model_valid(a, m, 1'b0)), $sformatf("valid on read of %h", a));
		if (!model_mapped(a))
			check(read_data, '0, $sformatf("unmapped read of %h", a));
		check(read_data, e, $sformatf("read of %h", a));
	endtask

	task automatic read_bound(input logic [31:0] a, input logic [2:0] m, input logic [31:0] e);
		drive_access(a, m, 1'b0, '0);
		check(32'(read_data <= e), 32'd1, $sformatf("read of %h above %h", a, e));
	endtask

	task automatic wait_irq(input logic [31:0] b, input logic [31:0] limit);
		logic [31:0] mask;
		logic [31:0] n;
		mask = 32'd1 << (b - 32'd2); // hwirq starts at bit 2
		n    = '0;
		next_cycle();
		@(negedge clk);
		while ((32'(hwirq) & mask) == '0) begin
			if (n >= limit)
				abort_run($sformatf("Timed out after %0d cycles waiting for hwirq bit %0d",
					n, b));
			n = n + 32'd1;
			@(negedge clk);
		end
	endtask

	initial begin
		logic [111:0]                rec;
		logic [7:0]                  op;
		logic [31:0]                 a;
		logic [31:0]                 d;
		logic [7:0]                  m;
		logic [31:0]                 e;
		logic [$clog2(MAX_RECS)-1:0] ri;
		int                          n_ops;
		logic                        done;

		arst_n       = 1'b0;
		dm_mode      = DM_NONE;
		stop         = 1'b0;
		addr         = '0;
		write_enable = 1'b0;
		write_data   = '0;
		switches     = '0;
		buttons      = '0;
		ri           = '0;
		repeat (MAX_RECS) begin
			recs[ri] = '0;
			ri = ri + 1'b1;
		end
		$readmemh("bench/mmio_tests.txt", recs);

		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;

		done  = 1'b0;
		n_ops = 0;
		ri    = '0;
		while (!done) begin
			rec = recs[ri];
			op  = rec[111:104];
			a   = rec[103:72];
			d   = rec[71:40];
			m   = rec[39:32];
			e   = rec[31:0];
			case (op)
				8'h00: done = 1'b1;
				8'h01: do_write(a, d, m[2:0], e);
				8'h02: do_read(a, m[2:0], e);
				8'h03: do_access(a, m[2:0], e);
				8'h04: begin
					next_cycle();
					switches = d[15:0];
				end
				8'h05: begin
					next_cycle();
					buttons = d[4:0];
				end
				8'h06: begin
					next_cycle();
					stop = d[0];
				end
				8'h07: wait_irq(a, d);
				8'h08: begin
					next_cycle();
					@(negedge clk);
					check(32'(hwirq), e, "hwirq vector");
				end
				8'h09: read_bound(a, m[2:0], e);
				8'h0A: begin
					next_cycle();
					@(negedge clk);
					check(32'(leds), e, "led outputs");
				end
				default: abort_run($sformatf("Unknown operation %h in test line %0d", op, ri));
			endcase
			if (!done) begin
				n_ops = n_ops + 1;
				if (ri == '1)
					done = 1'b1;
				else
					ri = ri + 1'b1;
			end
		end

		if (n_ops == 0) begin
			abort_run("No operations were read from bench/mmio_tests.txt");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

// File: bench/mmio_tests.txt
// Columns op_addr_data_mode_expected in hex, mode 00 none 01 word 02 half 03 byte
// op 01 write 02 read 03 access 04 switches 05 buttons 06 stop 07 wait irq 08 hwirq 09 bound 0A leds
01_00007F10_0000A5A5_01_00000001
0A_00000000_00000000_00_0000A5A5
02_00007F10_00000000_01_0000A5A5
01_00007F12_1234BEEF_03_00000001
02_00007F10_00000000_01_0000BEEF
02_00007F40_00000000_01_00000000
03_00007F40_00000000_01_00000000
03_00007F44_00000000_00_00000001
01_00007F50_FFFFFFFF_01_00000000
03_00007F00_00000000_03_00000000
03_00007F06_00000000_01_00000000
01_00007F08_00000010_01_00000000
02_00007F08_00000000_01_00000000
01_00007F00_00000000_01_00000001
06_00000000_00000001_00_00000000
01_00007F10_00001111_01_00000001
06_00000000_00000000_00_00000000
02_00007F10_00000000_01_0000BEEF
01_00007F04_00000005_01_00000001
02_00007F08_00000000_01_00000005
01_00007F00_00000009_01_00000001
07_00000002_00000020_00_00000000
02_00007F00_00000000_01_00000008
08_00000000_00000000_00_00000001
01_00007F00_00000000_01_00000001
08_00000000_00000000_00_00000000
04_00000000_0000A5C3_00_00000000
07_00000004_00000010_00_00000000
02_00007F20_00000000_03_0000A5C3
08_00000000_00000000_00_00000004
01_00007F20_00000000_01_00000001
08_00000000_00000000_00_00000000
05_00000000_00000015_00_00000000
07_00000007_00000010_00_00000000
02_00007F30_00000000_02_00000015
08_00000000_00000000_00_00000020
01_00007F30_00000000_02_00000001
08_00000000_00000000_00_00000000
01_00007F04_00000003_01_00000001
01_00007F00_0000000B_01_00000001
09_00007F08_00000000_01_00000003
07_00000002_00000020_00_00000000
09_00007F08_00000000_01_00000003
01_00007F00_0000000B_01_00000001
08_00000000_00000000_00_00000000
07_00000002_00000020_00_00000000
02_00007F04_00000000_01_00000003
01_00007F00_00000000_01_00000001
08_00000000_00000000_00_00000000
00_00000000_00000000_00_00000000

// File: sources.f
hw/mmio_pkg.sv
hw/dev_bus_if.sv
hw/bridge.sv
hw/timer.sv
hw/led_port.sv
hw/input_port.sv
hw/mmio_top.sv
bench/mmio_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the MMIO testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module mmio_top_tb \
	-f sources.f \
	-o mmio_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/mmio_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation run failed with status $sim_status"
	exit $sim_status
fi

exit 0
